// ==== source/siHistPkg.sv ====
`default_nettype none

package siHistPkg;

    // bits per time-bin index, 64 bins by default
    localparam int binWidth = 6;

    // bits per pixel index, 4 pixels share one counting memory
    localparam int pixelWidth = 2;

    // bits per bin count
    // counts stop at all ones
    localparam int countWidth = 8;

    // time-bin index
    typedef logic [binWidth-1:0] binT;

    // pixel index
    typedef logic [pixelWidth-1:0] pixelT;

    // histogram count of one bin
    typedef logic [countWidth-1:0] countT;

    // acquisition controller states
    typedef enum logic [1:0] {
        stateIdle,
        stateAcquire,
        stateScan,
        stateDrain
    } ctrlStateT;

endpackage

`default_nettype wire

// ==== source/acquisitionControl.sv ====
`default_nettype none

module acquisitionControl
    import siHistPkg::*;
#(
    parameter int binWidth   = siHistPkg::binWidth,
    parameter int pixelWidth = siHistPkg::pixelWidth
) (
    input  wire   clk,
    input  wire   reset,
    input  wire   acqStart,
    input  wire   acqStop,
    output logic  busy,
    output logic  acquiring,
    output logic  scanValid,
    output pixelT scanPixel,
    output binT   scanBin,
    output logic  scanFirst,
    output logic  scanLast
);

    // one combined counter walks every bin of every pixel
    localparam int addrWidth = pixelWidth + binWidth;
    localparam logic [addrWidth-1:0] lastAddr = '1;
    localparam logic [binWidth-1:0] firstBin = '0;
    localparam logic [binWidth-1:0] lastBin = '1;

    // cycles for the memory and peak stages to empty after the scan
    localparam int drainCycles = 2;
    localparam logic [1:0] drainLast = 2'(drainCycles - 1);

    ctrlStateT state;
    ctrlStateT stateNext;

    logic [addrWidth-1:0] scanCount;
    logic [1:0]           drainCount;

    always_comb begin
        stateNext = state;
        case (state)
            stateIdle: begin
                // start only from idle
                if (acqStart) begin
                    stateNext = stateAcquire;
                end
            end
            stateAcquire: begin
                if (acqStop) begin
                    stateNext = stateScan;
                end
            end
            stateScan: begin
                // final bin of the final pixel
                if (scanCount == lastAddr) begin
                    stateNext = stateDrain;
                end
            end
            stateDrain: begin
                if (drainCount == drainLast) begin
                    stateNext = stateIdle;
                end
            end
            default: begin
                stateNext = stateIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state      <= stateIdle;
            scanCount  <= '0;
            drainCount <= '0;
        end else begin
            state <= stateNext;

            // counter wraps back to zero at the end of the scan
            if (state == stateScan) begin
                scanCount <= scanCount + 1'b1;
            end else begin
                scanCount <= '0;
            end

            if (state == stateDrain) begin
                drainCount <= drainCount + 1'b1;
            end else begin
                drainCount <= '0;
            end
        end
    end

    // busy covers acquisition, scan and drain
    assign busy      = (state != stateIdle);
    // gates the increment port of the memory
    assign acquiring = (state == stateAcquire);
    assign scanValid = (state == stateScan);

    // pixel in the upper field, bin in the lower
    assign scanPixel = scanCount[addrWidth-1:binWidth];
    assign scanBin   = scanCount[binWidth-1:0];

    // pixel boundaries, decoded from the bin field
    assign scanFirst = scanValid && (scanBin == firstBin);
    assign scanLast  = scanValid && (scanBin == lastBin);

endmodule

`default_nettype wire

// ==== source/histogramMemory.sv ====
`default_nettype none

module histogramMemory
    import siHistPkg::*;
#(
    parameter int binWidth   = siHistPkg::binWidth,
    parameter int pixelWidth = siHistPkg::pixelWidth,
    parameter int countWidth = siHistPkg::countWidth
) (
    input  wire   clk,
    input  wire   reset,
    input  wire   acquiring,
    input  wire   hitValid,
    input  pixelT hitPixel,
    input  binT   hitBin,
    input  wire   scanValid,
    input  pixelT scanPixel,
    input  binT   scanBin,
    input  wire   scanFirst,
    input  wire   scanLast,
    output logic  countValid,
    output countT binCount,
    output pixelT countPixel,
    output binT   countBin,
    output logic  countFirst,
    output logic  countLast
);

    // address is {pixel, bin}, one row of binNum counts per pixel
    localparam int addrWidth = pixelWidth + binWidth;
    localparam int depth = 1 << addrWidth;
    localparam logic [countWidth-1:0] countMax = '1;

    logic [countWidth-1:0] countArray [depth];
    // per-entry flag, an entry without it reads as zero
    logic [depth-1:0] entryLive;

    logic                  hitAccept;
    logic [addrWidth-1:0]  hitAddr;
    logic [countWidth-1:0] hitStored;
    logic [countWidth-1:0] hitCurrent;
    logic [countWidth-1:0] hitNext;

    // increment pipeline stage, written one cycle after the read
    logic                  incValid;
    logic [addrWidth-1:0]  incAddr;
    logic [countWidth-1:0] incData;

    logic [addrWidth-1:0]  scanAddr;
    logic [countWidth-1:0] scanStored;
    logic [countWidth-1:0] scanCurrent;

    // hits outside the window are dropped here
    assign hitAccept = hitValid && acquiring;
    assign hitAddr   = {hitPixel, hitBin};
    assign hitStored = entryLive[hitAddr] ? countArray[hitAddr] : '0;

    // forward the pending write so back-to-back hits all count
    assign hitCurrent = (incValid && (incAddr == hitAddr)) ? incData : hitStored;
    // saturate at the top count
    assign hitNext = (hitCurrent == countMax) ? hitCurrent : hitCurrent + 1'b1;

    assign scanAddr   = {scanPixel, scanBin};
    assign scanStored = entryLive[scanAddr] ? countArray[scanAddr] : '0;
    // last hit of the window may still be in flight on the first scan cycle
    assign scanCurrent = (incValid && (incAddr == scanAddr)) ? incData : scanStored;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            incValid   <= 1'b0;
            entryLive  <= '0;
            countValid <= 1'b0;
            countFirst <= 1'b0;
            countLast  <= 1'b0;
        end else begin
            incValid   <= hitAccept;
            countValid <= scanValid;
            countFirst <= scanFirst;
            countLast  <= scanLast;
            if (incValid) begin
                entryLive[incAddr] <= 1'b1;
            end
            // scan clear wins over a pending write to the same entry
            if (scanValid) begin
                entryLive[scanAddr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hitAccept) begin
            incAddr <= hitAddr;
            incData <= hitNext;
        end
        if (incValid) begin
            countArray[incAddr] <= incData;
        end
        // read and clear, next acquisition starts from zero
        if (scanValid) begin
            countArray[scanAddr] <= '0;
        end
    end

    // scan data with its address, one cycle behind the request
    always_ff @(posedge clk) begin
        if (scanValid) begin
            binCount   <= scanCurrent;
            countPixel <= scanPixel;
            countBin   <= scanBin;
        end
    end

endmodule

`default_nettype wire

// ==== source/peakDetector.sv ====
`default_nettype none

module peakDetector
    import siHistPkg::*;
#(
    parameter int binWidth   = siHistPkg::binWidth,
    parameter int pixelWidth = siHistPkg::pixelWidth,
    parameter int countWidth = siHistPkg::countWidth
) (
    input  wire   clk,
    input  wire   reset,
    input  wire   countValid,
    input  countT binCount,
    input  pixelT countPixel,
    input  binT   countBin,
    input  wire   countFirst,
    input  wire   countLast,
    output logic  peakDone,
    output pixelT peakPixel,
    output binT   peakBin,
    output countT peakCount
);

    localparam int addrWidth = pixelWidth + binWidth;

    // running maximum of the current pixel and its {pixel, bin}
    logic [countWidth-1:0] recentMax;
    logic [addrWidth-1:0]  maxAddr;

    logic [countWidth-1:0] nextMax;
    logic [addrWidth-1:0]  nextAddr;

    // first bin reloads, later bins only win when strictly larger
    // so a tie keeps the lower bin
    always_comb begin
        if (countFirst || (binCount > recentMax)) begin
            nextMax  = binCount;
            nextAddr = {countPixel, countBin};
        end else begin
            nextMax  = recentMax;
            nextAddr = maxAddr;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            recentMax <= '0;
            maxAddr   <= '0;
            peakDone  <= 1'b0;
            peakPixel <= '0;
            peakBin   <= '0;
            peakCount <= '0;
        end else begin
            peakDone <= 1'b0;
            if (countValid) begin
                recentMax <= nextMax;
                maxAddr   <= nextAddr;
                // last bin of the pixel, report including this bin
                if (countLast) begin
                    peakDone  <= 1'b1;
                    peakCount <= nextMax;
                    peakPixel <= nextAddr[addrWidth-1:binWidth];
                    peakBin   <= nextAddr[binWidth-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/histogramTop.sv ====
`default_nettype none

module histogramTop
    import siHistPkg::*;
#(
    parameter int binWidth   = siHistPkg::binWidth,
    parameter int pixelWidth = siHistPkg::pixelWidth,
    parameter int countWidth = siHistPkg::countWidth
) (
    input  wire   clk,
    input  wire   reset,
    input  wire   acqStart,
    input  wire   acqStop,
    input  wire   hitValid,
    input  pixelT hitPixel,
    input  binT   hitBin,
    output logic  busy,
    output logic  peakDone,
    output pixelT peakPixel,
    output binT   peakBin,
    output countT peakCount
);

    // controller to memory
    logic  acquiring;
    logic  scanValid;
    pixelT scanPixel;
    binT   scanBin;
    logic  scanFirst;
    logic  scanLast;

    // memory to peak detector, one cycle behind the scan
    logic  countValid;
    countT binCount;
    pixelT countPixel;
    binT   countBin;
    logic  countFirst;
    logic  countLast;

    // window control and scan address generation
    acquisitionControl #(
        .binWidth   (binWidth),
        .pixelWidth (pixelWidth)
    ) u_control (
        .clk       (clk),
        .reset     (reset),
        .acqStart  (acqStart),
        .acqStop   (acqStop),
        .busy      (busy),
        .acquiring (acquiring),
        .scanValid (scanValid),
        .scanPixel (scanPixel),
        .scanBin   (scanBin),
        .scanFirst (scanFirst),
        .scanLast  (scanLast)
    );

    // shared counting RAM for all pixels
    histogramMemory #(
        .binWidth   (binWidth),
        .pixelWidth (pixelWidth),
        .countWidth (countWidth)
    ) u_memory (
        .clk        (clk),
        .reset      (reset),
        .acquiring  (acquiring),
        .hitValid   (hitValid),
        .hitPixel   (hitPixel),
        .hitBin     (hitBin),
        .scanValid  (scanValid),
        .scanPixel  (scanPixel),
        .scanBin    (scanBin),
        .scanFirst  (scanFirst),
        .scanLast   (scanLast),
        .countValid (countValid),
        .binCount   (binCount),
        .countPixel (countPixel),
        .countBin   (countBin),
        .countFirst (countFirst),
        .countLast  (countLast)
    );

    // per-pixel peak search over the scanned counts
    peakDetector #(
        .binWidth   (binWidth),
        .pixelWidth (pixelWidth),
        .countWidth (countWidth)
    ) u_peak (
        .clk        (clk),
        .reset      (reset),
        .countValid (countValid),
        .binCount   (binCount),
        .countPixel (countPixel),
        .countBin   (countBin),
        .countFirst (countFirst),
        .countLast  (countLast),
        .peakDone   (peakDone),
        .peakPixel  (peakPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount)
    );

endmodule

`default_nettype wire

// ==== verification/histogramTasks.svh ====
// one dominant bin per pixel, a different count for each pixel
task automatic singlePeakTest();
    int errorsBefore;
    errorsBefore = errorCount;
    clearModel();
    startAcq();
    for (int p = 0; p < pixelNum; p++) begin
        // weaker bin next to the peak
        driveHit(p, p * 5, 1'b1);
        for (int n = 0; n < 3 * (p + 2); n++) begin
            driveHit(p, 7 + 17 * p, 1'b1);
        end
    end
    stopAcq();
    collectPeaks();
    reportTest("single peak per pixel", errorsBefore);
endtask

// LFSR addresses, repeats back to back and idle gaps
task automatic randomHitTest();
    int errorsBefore;
    int p;
    int b;
    errorsBefore = errorCount;
    p = 0;
    b = 0;
    clearModel();
    startAcq();
    for (int n = 0; n < 400; n++) begin
        // about one hit in four repeats the previous address
        if (n == 0 || takeBits(2) != 0) begin
            p = takeBits(pixelWidth);
            b = takeBits(binWidth);
        end
        driveHit(p, b, 1'b1);
        if (takeBits(3) == 0) begin
            endHits();
        end
    end
    stopAcq();
    collectPeaks();
    reportTest("random hits", errorsBefore);
endtask

// pixel 1 has a tie at bins 10 and 40, pixel 2 stays empty
task automatic tieEmptyTest();
    int errorsBefore;
    errorsBefore = errorCount;
    clearModel();
    startAcq();
    for (int n = 0; n < 4; n++) begin
        driveHit(1, 40, 1'b1);
        driveHit(1, 10, 1'b1);
    end
    driveHit(1, 20, 1'b1);
    driveHit(0, binNum - 1, 1'b1);
    driveHit(3, 0, 1'b1);
    stopAcq();
    collectPeaks();
    reportTest("tie and empty histogram", errorsBefore);
endtask

task automatic saturationTest();
    int errorsBefore;
    errorsBefore = errorCount;
    clearModel();
    startAcq();
    driveHit(0, 1, 1'b1);
    for (int n = 0; n < countMax + 45; n++) begin
        driveHit(3, 33, 1'b1);
    end
    stopAcq();
    collectPeaks();
    // pixel 3 reports last, its count held at all ones
    checkValue("peakCount", countMax, peakCount);
    reportTest("saturation", errorsBefore);
endtask

// idle and scan hits are dropped, the scan leaves the memory empty
task automatic clearGatingTest();
    int errorsBefore;
    errorsBefore = errorCount;
    clearModel();
    for (int n = 0; n < 10; n++) begin
        randomHit(1'b0);
    end
    startAcq();
    for (int n = 0; n < 40; n++) begin
        randomHit(1'b1);
    end
    stopAcq();
    for (int n = 0; n < 20; n++) begin
        randomHit(1'b0);
    end
    endHits();
    collectPeaks();
    clearModel();
    startAcq();
    for (int n = 0; n < 40; n++) begin
        randomHit(1'b1);
    end
    stopAcq();
    collectPeaks();
    reportTest("clearing and gating", errorsBefore);
endtask

task automatic scanTimingTest();
    int errorsBefore;
    errorsBefore = errorCount;
    clearModel();
    startAcq();
    for (int n = 0; n < 30; n++) begin
        randomHit(1'b1);
    end
    stopAcq();
    collectPeaks();
    // counted from the edge that drove acqStop, stopAcq used up one
    checkValue("peakDone delay", binNum + 2, peakGap[0] + 1);
    for (int p = 1; p < pixelNum; p++) begin
        checkValue("peakDone interval", binNum, peakGap[p]);
    end
    reportTest("scan timing", errorsBefore);
endtask

// ==== verification/histogramTb.sv ====
`default_nettype none

module histogramTb
    import siHistPkg::*;
();

    localparam int pixelNum = 1 << pixelWidth;
    localparam int binNum = 1 << binWidth;
    localparam int countMax = (1 << countWidth) - 1;
    // longest wait for any DUT event, in clock cycles
    localparam int waitLimit = 2000;

    logic  clk;
    logic  reset;
    logic  acqStart;
    logic  acqStop;
    logic  hitValid;
    pixelT hitPixel;
    binT   hitBin;
    logic  busy;
    logic  peakDone;
    pixelT peakPixel;
    binT   peakBin;
    countT peakCount;

    // reference histogram, one count per pixel and bin
    int modelCount [pixelNum][binNum];
    // falling edges waited for each peakDone of the last scan
    int peakGap [pixelNum];
    logic [31:0] lfsrState;
    int errorCount;
    int checkCount;
    // set once a wait runs out, later waits return at once
    bit hung;

    histogramTop u_dut (
        .clk       (clk),
        .reset     (reset),
        .acqStart  (acqStart),
        .acqStop   (acqStop),
        .hitValid  (hitValid),
        .hitPixel  (hitPixel),
        .hitBin    (hitBin),
        .busy      (busy),
        .peakDone  (peakDone),
        .peakPixel (peakPixel),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic int takeBits(input int n);
        int value;
        logic feedback;
        value = 0;
        for (int i = 0; i < n; i++) begin
            feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value = (value << 1) | int'(feedback);
        end
        return value;
    endfunction

    task automatic clearModel();
        for (int p = 0; p < pixelNum; p++) begin
            for (int b = 0; b < binNum; b++) begin
                modelCount[p][b] = 0;
            end
        end
    endtask

    task automatic checkValue(input string name, input int expected, input int actual);
        checkCount++;
        if (expected != actual) begin
            errorCount++;
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    // one hit per falling edge, the model counts it only inside the window
    task automatic driveHit(input int p, input int b, input bit counted);
        @(negedge clk);
        hitValid = 1'b1;
        hitPixel = pixelT'(p);
        hitBin   = binT'(b);
        if (counted && modelCount[p][b] < countMax) begin
            modelCount[p][b]++;
        end
    endtask

    task automatic randomHit(input bit counted);
        int p;
        int b;
        p = takeBits(pixelWidth);
        b = takeBits(binWidth);
        driveHit(p, b, counted);
    endtask

    task automatic endHits();
        @(negedge clk);
        hitValid = 1'b0;
    endtask

    task automatic startAcq();
        @(negedge clk);
        hitValid = 1'b0;
        acqStart = 1'b1;
        @(negedge clk);
        acqStart = 1'b0;
    endtask

    // returns one falling edge after acqStop was driven
    task automatic stopAcq();
        @(negedge clk);
        hitValid = 1'b0;
        acqStop  = 1'b1;
        @(negedge clk);
        acqStop = 1'b0;
    endtask

    task automatic waitPeakDone(output bit seen, output int cycles);
        seen = 1'b0;
        cycles = 0;
        while (!seen && !hung && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
            seen = peakDone;
        end
        if (!seen && !hung) begin
            $display("timeout at %0t: no peakDone pulse within %0d cycles", $time, waitLimit);
            errorCount++;
            hung = 1'b1;
        end
    endtask

    task automatic waitIdle();
        int cycles;
        cycles = 0;
        while (busy && !hung && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (busy && !hung) begin
            $display("timeout at %0t: busy stayed high after the last peak", $time);
            errorCount++;
            hung = 1'b1;
        end
    endtask

    // peak from the model, strictly larger wins so ties keep the lower bin
    task automatic checkPeak(input int p);
        int bestBin;
        int bestCount;
        bestBin = 0;
        bestCount = modelCount[p][0];
        for (int b = 1; b < binNum; b++) begin
            if (modelCount[p][b] > bestCount) begin
                bestBin = b;
                bestCount = modelCount[p][b];
            end
        end
        checkValue("peakPixel", p, peakPixel);
        checkValue("peakBin", bestBin, peakBin);
        checkValue("peakCount", bestCount, peakCount);
    endtask

    // pixels report in order, busy drops once the drain ends
    task automatic collectPeaks();
        bit seen;
        int cycles;
        for (int p = 0; p < pixelNum; p++) begin
            waitPeakDone(seen, cycles);
            if (!seen) begin
                return;
            end
            peakGap[p] = cycles;
            checkPeak(p);
        end
        checkValue("busy", 1, busy);
        waitIdle();
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        $display("test %s: %0d errors", name, errorCount - errorsBefore);
    endtask

    task automatic checkResetState();
        checkValue("busy", 0, busy);
        checkValue("peakDone", 0, peakDone);
        checkValue("peakPixel", 0, peakPixel);
        checkValue("peakBin", 0, peakBin);
        checkValue("peakCount", 0, peakCount);
    endtask

    `include "histogramTasks.svh"

    initial begin
        reset      = 1'b0;
        acqStart   = 1'b0;
        acqStop    = 1'b0;
        hitValid   = 1'b0;
        hitPixel   = '0;
        hitBin     = '0;
        lfsrState  = 32'h9a1c8edd;
        errorCount = 0;
        checkCount = 0;
        hung       = 1'b0;
        clearModel();
        repeat (8) @(negedge clk);
        checkResetState();
        reset = 1'b1;

        if (!hung) singlePeakTest();
        if (!hung) randomHitTest();
        if (!hung) tieEmptyTest();
        if (!hung) saturationTest();
        if (!hung) clearGatingTest();
        if (!hung) scanTimingTest();

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verification
source/siHistPkg.sv
source/acquisitionControl.sv
source/histogramMemory.sv
source/peakDetector.sv
source/histogramTop.sv
verification/histogramTb.sv

// ==== Bender.yml ====
package:
  name: siHist

sources:
  - source/siHistPkg.sv
  - source/acquisitionControl.sv
  - source/histogramMemory.sv
  - source/peakDetector.sv
  - source/histogramTop.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/histogramTb.sv
